// File: include/cpu_settings.svh
`ifndef CPU_SETTINGS_SVH
`define CPU_SETTINGS_SVH

// Main bus and register width
`define DATA_W 8

// Address bus and MAR width
`define ADDR_W 16

// Low address bits decoded by the RAM, fewer bits alias the upper range
`define RAM_AW 16

`endif

// File: source/cpu_ctrl_pkg.sv
package cpu_ctrl_pkg;

    typedef logic [31:0] ctrl_word_t;

    // Control word field positions
    localparam int BUS_SRC_LO = 0;
    localparam int BUS_SRC_W = 4;
    localparam int ALU_OP_LO = 4;
    localparam int ALU_OP_W = 4;
    localparam int BIT_LOAD_A = 8;
    localparam int BIT_A_FROM_ALU = 9;
    localparam int BIT_LOAD_B = 10;
    localparam int BIT_LOAD_F = 11;
    localparam int BIT_LOAD_MAR_LO = 12;
    localparam int BIT_LOAD_MAR_HI = 13;
    localparam int BIT_RAM_WE = 14;
    localparam int BIT_LOAD_OUT = 15;

    // Main bus sources, unlisted codes read 0
    typedef enum logic [3:0] {
        SRC_NONE = 4'd0,
        SRC_A = 4'd1,
        SRC_B = 4'd2,
        SRC_F = 4'd3,
        SRC_ALU = 4'd4,
        SRC_RAM = 4'd5,
        SRC_MAR_LO = 4'd6,
        SRC_MAR_HI = 4'd7,
        SRC_OUT = 4'd8
    } bus_src_t;

    // ALU operations, unlisted codes pass A
    typedef enum logic [3:0] {
        ALU_PASS_A = 4'd0,
        ALU_ADD = 4'd1,
        ALU_SUB = 4'd2,
        ALU_AND = 4'd3,
        ALU_OR = 4'd4,
        ALU_XOR = 4'd5,
        ALU_CLR = 4'd6,
        ALU_INC = 4'd7,
        ALU_NOT_A = 4'd8
    } alu_op_t;

endpackage

// File: source/cpu_data_pkg.sv
`include "cpu_settings.svh"

package cpu_data_pkg;

    typedef logic [`DATA_W-1:0] data_t;

    typedef logic [`ADDR_W-1:0] addr_t;

    // Flag register, upper nibble always zero
    typedef struct packed {
        logic [3:0] unused;
        logic overflow;
        logic negative;
        logic zero;
        logic carry;
    } flags_t;

endpackage

// File: source/alu_regs.sv
module alu_regs (
    input  logic                  clk,
    input  logic                  arst_n,
    input  cpu_ctrl_pkg::alu_op_t alu_op,
    input  logic                  load_a,
    input  logic                  a_from_alu,
    input  logic                  load_b,
    input  logic                  load_f,
    input  cpu_data_pkg::data_t   bus_in,
    output cpu_data_pkg::data_t   a_value,
    output cpu_data_pkg::data_t   b_value,
    output cpu_data_pkg::data_t   alu_result,
    output cpu_data_pkg::flags_t  f_value
);

    import cpu_ctrl_pkg::*;
    import cpu_data_pkg::*;

    localparam int W = $bits(data_t);
    localparam int MSB = W - 1;

    data_t a_reg;
    data_t b_reg;
    flags_t f_reg;

    data_t result;
    flags_t flags_next;
    logic carry;
    logic ovf;

    // Carry or borrow lands in the extra top bit
    logic [W:0] sum_ab;
    logic [W:0] diff_ab;
    logic [W:0] inc_a;

    assign sum_ab = {1'b0, a_reg} + {1'b0, b_reg};
    assign diff_ab = {1'b0, a_reg} - {1'b0, b_reg};
    assign inc_a = {1'b0, a_reg} + 1'b1;

    always_comb begin
        result = a_reg;
        carry = 1'b0;
        ovf = 1'b0;
        case (alu_op)
            ALU_ADD: begin
                result = sum_ab[MSB:0];
                carry = sum_ab[W];
                ovf = (a_reg[MSB] == b_reg[MSB]) && (result[MSB] != a_reg[MSB]);
            end
            ALU_SUB: begin
                result = diff_ab[MSB:0];
                carry = diff_ab[W];
                ovf = (a_reg[MSB] != b_reg[MSB]) && (result[MSB] != a_reg[MSB]);
            end
            ALU_AND: result = a_reg & b_reg;
            ALU_OR: result = a_reg | b_reg;
            ALU_XOR: result = a_reg ^ b_reg;
            ALU_CLR: result = '0;
            ALU_INC: begin
                result = inc_a[MSB:0];
                carry = inc_a[W];
                // Only 0x7f wraps into the negative range
                ovf = !a_reg[MSB] && result[MSB];
            end
            ALU_NOT_A: result = ~a_reg;
            ALU_PASS_A: result = a_reg;
            default: result = a_reg;
        endcase
    end

    always_comb begin
        flags_next = '0;
        flags_next.carry = carry;
        flags_next.zero = (result == '0);
        flags_next.negative = result[MSB];
        flags_next.overflow = ovf;
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            a_reg <= '0;
            b_reg <= '0;
            f_reg <= '0;
        end else begin
            if (load_a) begin
                a_reg <= a_from_alu ? result : bus_in;
            end
            if (load_b) begin
                b_reg <= bus_in;
            end
            if (load_f) begin
                f_reg <= flags_next;
            end
        end
    end

    assign a_value = a_reg;
    assign b_value = b_reg;
    assign alu_result = result;
    assign f_value = f_reg;

endmodule

// File: source/mem_unit.sv
`include "cpu_settings.svh"

module mem_unit (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                load_mar_lo,
    input  logic                load_mar_hi,
    input  logic                ram_we,
    input  cpu_data_pkg::addr_t ext_addr,
    input  logic                ext_addr_drive,
    input  cpu_data_pkg::data_t bus_in,
    output cpu_data_pkg::addr_t mar_value,
    output cpu_data_pkg::data_t ram_rdata
);

    import cpu_data_pkg::*;

    localparam int DW = $bits(data_t);
    localparam int AW = $bits(addr_t);
    localparam int DEPTH = 2 ** `RAM_AW;

    addr_t mar;
    addr_t ram_addr;
    logic [`RAM_AW-1:0] ram_idx;

    data_t ram [DEPTH];

    // MAR is filled one byte at a time from the bus
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            mar <= '0;
        end else begin
            if (load_mar_lo) begin
                mar[DW-1:0] <= bus_in;
            end
            if (load_mar_hi) begin
                mar[AW-1:DW] <= bus_in;
            end
        end
    end

    // External driver overrides MAR
    assign ram_addr = ext_addr_drive ? ext_addr : mar;
    assign ram_idx = ram_addr[`RAM_AW-1:0];

    always_ff @(posedge clk) begin
        if (ram_we) begin
            ram[ram_idx] <= bus_in;
        end
    end

    // Asynchronous read port
    assign ram_rdata = ram[ram_idx];
    assign mar_value = mar;

endmodule

// File: source/bus_select.sv
module bus_select (
    input  logic                   clk,
    input  logic                   arst_n,
    input  cpu_ctrl_pkg::bus_src_t bus_src,
    input  cpu_data_pkg::data_t    ext_data,
    input  logic                   ext_data_drive,
    input  cpu_data_pkg::data_t    a_value,
    input  cpu_data_pkg::data_t    b_value,
    input  cpu_data_pkg::data_t    alu_result,
    input  cpu_data_pkg::data_t    ram_rdata,
    input  cpu_data_pkg::flags_t   f_value,
    input  cpu_data_pkg::addr_t    mar_value,
    input  logic                   load_out,
    input  logic                   out_rst,
    output cpu_data_pkg::data_t    main_bus,
    output cpu_data_pkg::data_t    out_value
);

    import cpu_ctrl_pkg::*;
    import cpu_data_pkg::*;

    localparam int DW = $bits(data_t);
    localparam int AW = $bits(addr_t);

    data_t unit_bus;
    data_t out_reg;

    always_comb begin
        case (bus_src)
            SRC_A: unit_bus = a_value;
            SRC_B: unit_bus = b_value;
            SRC_F: unit_bus = data_t'(f_value);
            SRC_ALU: unit_bus = alu_result;
            SRC_RAM: unit_bus = ram_rdata;
            SRC_MAR_LO: unit_bus = mar_value[DW-1:0];
            SRC_MAR_HI: unit_bus = mar_value[AW-1:DW];
            SRC_OUT: unit_bus = out_reg;
            SRC_NONE: unit_bus = '0;
            default: unit_bus = '0;
        endcase
    end

    // Outside driver wins over any internal source
    assign main_bus = ext_data_drive ? ext_data : unit_bus;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            out_reg <= '0;
        end else if (out_rst) begin
            out_reg <= '0;
        end else if (load_out) begin
            out_reg <= main_bus;
        end
    end

    assign out_value = out_reg;

endmodule

// File: source/cpu.sv
module cpu (
    input  logic                     clk,
    input  logic                     arst_n,
    input  cpu_ctrl_pkg::ctrl_word_t control_word,
    input  cpu_data_pkg::data_t      ext_data,
    input  logic                     ext_data_drive,
    input  cpu_data_pkg::addr_t      ext_addr,
    input  logic                     ext_addr_drive,
    input  logic                     out_rst,
    output cpu_data_pkg::data_t      main_bus,
    output cpu_data_pkg::data_t      out_value
);

    import cpu_ctrl_pkg::*;
    import cpu_data_pkg::*;

    bus_src_t bus_src;
    alu_op_t alu_op;

    data_t a_value;
    data_t b_value;
    data_t alu_result;
    data_t ram_rdata;
    flags_t f_value;
    addr_t mar_value;

    // Upper half of the control word is unused
    assign bus_src = bus_src_t'(control_word[BUS_SRC_LO +: BUS_SRC_W]);
    assign alu_op = alu_op_t'(control_word[ALU_OP_LO +: ALU_OP_W]);

    alu_regs u_alu_regs (
        .clk        (clk),
        .arst_n     (arst_n),
        .alu_op     (alu_op),
        .load_a     (control_word[BIT_LOAD_A]),
        .a_from_alu (control_word[BIT_A_FROM_ALU]),
        .load_b     (control_word[BIT_LOAD_B]),
        .load_f     (control_word[BIT_LOAD_F]),
        .bus_in     (main_bus),
        .a_value    (a_value),
        .b_value    (b_value),
        .alu_result (alu_result),
        .f_value    (f_value)
    );

    mem_unit u_mem_unit (
        .clk            (clk),
        .arst_n         (arst_n),
        .load_mar_lo    (control_word[BIT_LOAD_MAR_LO]),
        .load_mar_hi    (control_word[BIT_LOAD_MAR_HI]),
        .ram_we         (control_word[BIT_RAM_WE]),
        .ext_addr       (ext_addr),
        .ext_addr_drive (ext_addr_drive),
        .bus_in         (main_bus),
        .mar_value      (mar_value),
        .ram_rdata      (ram_rdata)
    );

    bus_select u_bus_select (
        .clk            (clk),
        .arst_n         (arst_n),
        .bus_src        (bus_src),
        .ext_data       (ext_data),
        .ext_data_drive (ext_data_drive),
        .a_value        (a_value),
        .b_value        (b_value),
        .alu_result     (alu_result),
        .ram_rdata      (ram_rdata),
        .f_value        (f_value),
        .mar_value      (mar_value),
        .load_out       (control_word[BIT_LOAD_OUT]),
        .out_rst        (out_rst),
        .main_bus       (main_bus),
        .out_value      (out_value)
    );

endmodule

// File: sim/tb_cpu.sv
module tb_cpu;

    import cpu_ctrl_pkg::*;
    import cpu_data_pkg::*;

    localparam logic [31:0] SEED = 32'heb0d_b4c8;
    localparam int PAIRS = 40;
    // Two cycles per operand pair plus two per ALU code
    localparam int SWEEP_CYCLES = PAIRS * (2 + 2 * 16);
    localparam int CYCLE_LIMIT = SWEEP_CYCLES + 640;

    // Control word strobes
    localparam ctrl_word_t LD_A = 32'h0000_0100;
    localparam ctrl_word_t A_ALU = 32'h0000_0200;
    localparam ctrl_word_t LD_B = 32'h0000_0400;
    localparam ctrl_word_t LD_F = 32'h0000_0800;
    localparam ctrl_word_t LD_MLO = 32'h0000_1000;
    localparam ctrl_word_t LD_MHI = 32'h0000_2000;
    localparam ctrl_word_t RAM_WE = 32'h0000_4000;
    localparam ctrl_word_t LD_OUT = 32'h0000_8000;

    logic clk;
    logic arst_n;
    ctrl_word_t control_word;
    data_t ext_data;
    logic ext_data_drive;
    addr_t ext_addr;
    logic ext_addr_drive;
    logic out_rst;
    data_t main_bus;
    data_t out_value;

    int errors;
    int checks;
    int cycles = 0;
    logic [31:0] rng;

    // Model of the memory and the output register
    data_t m_ram [int];
    data_t m_out;

    cpu dut (
        .clk            (clk),
        .arst_n         (arst_n),
        .control_word   (control_word),
        .ext_data       (ext_data),
        .ext_data_drive (ext_data_drive),
        .ext_addr       (ext_addr),
        .ext_addr_drive (ext_addr_drive),
        .out_rst        (out_rst),
        .main_bus       (main_bus),
        .out_value      (out_value)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: the run did not finish within %0d cycles", CYCLE_LIMIT);
            $display("=== FAIL ===");
            $finish;
        end
    end

    function automatic logic [31:0] lcg_next();
        rng = rng * 32'd1664525 + 32'd1013904223;
        return rng;
    endfunction

    function automatic ctrl_word_t ctl(input int src, input int op, input ctrl_word_t strobes);
        return strobes | ctrl_word_t'(op << 4) | ctrl_word_t'(src);
    endfunction

    // Returns {flags, result}
    function automatic logic [15:0] model_alu(input int op, input data_t a, input data_t b);
        int sum;
        int ssum;
        data_t r;
        logic c;
        logic v;
        c = 1'b0;
        ssum = 0;
        case (op)
            1: begin
                sum = int'(a) + int'(b);
                ssum = int'($signed(a)) + int'($signed(b));
                c = (sum > 255);
            end
            2: begin
                sum = int'(a) - int'(b);
                ssum = int'($signed(a)) - int'($signed(b));
                c = (sum < 0);
            end
            3: sum = int'(a & b);
            4: sum = int'(a | b);
            5: sum = int'(a ^ b);
            6: sum = 0;
            7: begin
                sum = int'(a) + 1;
                ssum = int'($signed(a)) + 1;
                c = (sum > 255);
            end
            8: sum = int'(data_t'(~a));
            default: sum = int'(a);
        endcase
        r = data_t'(sum);
        v = (ssum > 127) || (ssum < -128);
        return {4'b0000, v, r[7], r == 8'h00, c, r};
    endfunction

    task automatic drive(input ctrl_word_t cw, input data_t d, input logic dd,
                         input addr_t a, input logic ad, input logic orst);
        @(posedge clk);
        control_word <= cw;
        ext_data <= d;
        ext_data_drive <= dd;
        ext_addr <= a;
        ext_addr_drive <= ad;
        out_rst <= orst;
    endtask

    task automatic drive_ctrl(input ctrl_word_t cw);
        drive(cw, 8'h00, 1'b0, 16'h0000, 1'b0, 1'b0);
    endtask

    task automatic drive_ext(input ctrl_word_t cw, input data_t d);
        drive(cw, d, 1'b1, 16'h0000, 1'b0, 1'b0);
    endtask

    task automatic check_byte(input string name, input data_t expected, input data_t actual);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("FAIL %s expected %h got %h (cycle %0d)", name, expected, actual, cycles);
        end
    endtask

    task automatic apply_reset();
        @(posedge clk);
        arst_n <= 1'b0;
        control_word <= '0;
        ext_data_drive <= 1'b0;
        ext_addr_drive <= 1'b0;
        out_rst <= 1'b0;
        repeat (3) @(posedge clk);
        arst_n <= 1'b1;
        m_out = 8'h00;
    endtask

    task automatic add_from_bus();
        drive_ext(LD_A, 8'd24);
        drive_ext(LD_B, 8'd18);
        drive_ctrl(ctl(SRC_NONE, ALU_ADD, LD_A | A_ALU));
        drive_ctrl(ctl(SRC_A, 0, '0));
        @(negedge clk);
        check_byte("main_bus", 8'd42, main_bus);
    endtask

    task automatic sweep_alu();
        logic [31:0] r;
        data_t a;
        data_t b;
        logic [15:0] exp;
        for (int p = 0; p < PAIRS; p++) begin
            r = lcg_next();
            a = r[31:24];
            b = r[23:16];
            drive_ext(LD_A, a);
            drive_ext(LD_B, b);
            for (int op = 0; op < 16; op++) begin
                exp = model_alu(op, a, b);
                drive_ctrl(ctl(SRC_ALU, op, LD_F));
                @(negedge clk);
                check_byte("main_bus", exp[7:0], main_bus);
                drive_ctrl(ctl(SRC_F, op, '0));
                @(negedge clk);
                check_byte("main_bus(F)", exp[15:8], main_bus);
            end
        end
    endtask

    task automatic ram_both_paths();
        logic [31:0] r;
        r = lcg_next();
        drive(RAM_WE, 8'h54, 1'b1, 16'h1234, 1'b1, 1'b0);
        m_ram[16'h1234] = 8'h54;
        drive(ctl(SRC_RAM, 0, '0), 8'h00, 1'b0, 16'h1234, 1'b1, 1'b0);
        @(negedge clk);
        check_byte("main_bus", m_ram[16'h1234], main_bus);
        drive(RAM_WE, 8'hc3, 1'b1, 16'h1235, 1'b1, 1'b0);
        m_ram[16'h1235] = 8'hc3;
        drive(ctl(SRC_RAM, 0, '0), 8'h00, 1'b0, 16'h1234, 1'b1, 1'b0);
        @(negedge clk);
        check_byte("main_bus", m_ram[16'h1234], main_bus);
        drive(ctl(SRC_RAM, 0, '0), 8'h00, 1'b0, 16'h1235, 1'b1, 1'b0);
        @(negedge clk);
        check_byte("main_bus", m_ram[16'h1235], main_bus);
        // Build MAR from two bus bytes
        drive_ext(LD_MLO, 8'hef);
        drive_ext(LD_MHI, 8'hbe);
        drive_ctrl(ctl(SRC_MAR_LO, 0, '0));
        @(negedge clk);
        check_byte("main_bus(MAR_LO)", 8'hef, main_bus);
        drive_ctrl(ctl(SRC_MAR_HI, 0, '0));
        @(negedge clk);
        check_byte("main_bus(MAR_HI)", 8'hbe, main_bus);
        drive_ext(RAM_WE, r[31:24]);
        m_ram[16'hbeef] = r[31:24];
        drive_ctrl(ctl(SRC_RAM, 0, '0));
        @(negedge clk);
        check_byte("main_bus", m_ram[16'hbeef], main_bus);
        drive(ctl(SRC_RAM, 0, '0), 8'h00, 1'b0, 16'hbeef, 1'b1, 1'b0);
        @(negedge clk);
        check_byte("main_bus", m_ram[16'hbeef], main_bus);
    endtask

    task automatic clear_and_inc();
        drive_ctrl(ctl(SRC_NONE, ALU_CLR, LD_A | A_ALU | LD_F));
        drive_ctrl(ctl(SRC_A, 0, '0));
        @(negedge clk);
        check_byte("main_bus(A)", 8'h00, main_bus);
        drive_ctrl(ctl(SRC_F, 0, '0));
        @(negedge clk);
        check_byte("main_bus(F)", 8'h02, main_bus);
        drive_ext(LD_A, 8'h7f);
        drive_ctrl(ctl(SRC_NONE, ALU_INC, LD_A | A_ALU | LD_F));
        drive_ctrl(ctl(SRC_A, 0, '0));
        @(negedge clk);
        check_byte("main_bus(A)", 8'h80, main_bus);
        drive_ctrl(ctl(SRC_F, 0, '0));
        @(negedge clk);
        check_byte("main_bus(F)", 8'h0c, main_bus);
    endtask

    task automatic out_reg_hold_clear();
        // A still holds 0x80 here
        drive_ctrl(ctl(SRC_A, 0, LD_OUT));
        m_out = 8'h80;
        drive_ctrl(ctl(SRC_OUT, 0, '0));
        @(negedge clk);
        check_byte("out_value", m_out, out_value);
        check_byte("main_bus(OUT)", m_out, main_bus);
        drive_ext(ctl(SRC_NONE, 0, '0), 8'h3c);
        @(negedge clk);
        check_byte("main_bus", 8'h3c, main_bus);
        check_byte("out_value", m_out, out_value);
        drive(ctl(SRC_A, 0, LD_OUT), 8'h00, 1'b0, 16'h0000, 1'b0, 1'b1);
        m_out = 8'h00;
        drive_ctrl('0);
        @(negedge clk);
        check_byte("out_value", m_out, out_value);
    endtask

    task automatic ext_drive_priority();
        drive_ext(ctl(SRC_A, 0, '0), 8'h5a);
        @(negedge clk);
        check_byte("main_bus", 8'h5a, main_bus);
    endtask

    task automatic reset_state_zero();
        drive_ctrl(ctl(SRC_A, 0, LD_OUT));
        apply_reset();
        @(negedge clk);
        check_byte("main_bus", 8'h00, main_bus);
        check_byte("out_value", m_out, out_value);
        drive_ctrl(ctl(SRC_A, 0, '0));
        @(negedge clk);
        check_byte("main_bus(A)", 8'h00, main_bus);
    endtask

    initial begin
        arst_n = 1'b0;
        control_word = '0;
        ext_data = '0;
        ext_data_drive = 1'b0;
        ext_addr = '0;
        ext_addr_drive = 1'b0;
        out_rst = 1'b0;
        errors = 0;
        checks = 0;
        rng = SEED;
        apply_reset();
        add_from_bus();
        sweep_alu();
        ram_both_paths();
        clear_and_inc();
        out_reg_hold_clear();
        ext_drive_priority();
        reset_state_zero();
        @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule

// File: cpu.f
+incdir+include
source/cpu_ctrl_pkg.sv
source/cpu_data_pkg.sv
source/alu_regs.sv
source/mem_unit.sv
source/bus_select.sv
source/cpu.sv
sim/tb_cpu.sv

// File: Bender.yml
package:
  name: cpu

export_include_dirs:
  - include

sources:
  - include_dirs:
      - include
    files:
      - source/cpu_ctrl_pkg.sv
      - source/cpu_data_pkg.sv
      - source/alu_regs.sv
      - source/mem_unit.sv
      - source/bus_select.sv
      - source/cpu.sv
  - target: simulation
    include_dirs:
      - include
    files:
      - sim/tb_cpu.sv
